//--- Makefile
SRCS := $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)

.PHONY: all run check clean

all: obj_dir/csr_tb

obj_dir/csr_tb: tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module csr_tb -f tb.f -o csr_tb

run: obj_dir/csr_tb
	./obj_dir/csr_tb | tee sim.log
	grep -q "All tests passed" sim.log

check:
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hdl/csr_addr_pkg.sv
package csr_addr_pkg;

    typedef logic [13:0] csr_addr_t;

    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_EUEN   = 14'h002;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_BADV   = 14'h007;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    typedef enum logic [1:0] {
        CSR_RD   = 2'd0,  // csrrd
        CSR_WR   = 2'd1,  // csrwr
        CSR_XCHG = 2'd2   // csrxchg, masked write
    } csr_op_e;

    typedef enum logic [5:0] {
        ECODE_INT  = 6'h00,
        ECODE_ADEF = 6'h08,  // fetch address error
        ECODE_SYS  = 6'h0b,
        ECODE_BRK  = 6'h0c,
        ECODE_INE  = 6'h0d
    } ecode_t;

endpackage

//--- hdl/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// timer counter width, tval is loaded with initval * 4
`define CSR_TIMER_WID 32

// number of save0..saveN scratch registers
`define CSR_NUM_SAVE 4

// hardware interrupt lines, mapped onto estat.is[9:2]
`define CSR_NUM_HWI 8

`endif

//--- hdl/csr_excp.sv
`timescale 1ns/1ps

module csr_excp (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 excp_valid,
    input  csr_addr_pkg::ecode_t excp_ecode,
    input  logic [8:0]           excp_esubcode,
    input  logic [31:0]          excp_pc,
    input  logic [31:0]          excp_badv,
    input  logic                 ertn,
    input  csr_reg_pkg::crmd_u   crmd,
    input  csr_reg_pkg::prmd_t   prmd,
    input  csr_reg_pkg::estat_t  estat,
    input  logic [12:0]          ecfg,
    input  logic [31:0]          era,
    input  logic [31:0]          eentry,
    output logic                 excp_we,
    output logic [31:0]          excp_era,
    output logic [31:0]          excp_badv_out,
    output logic                 ertn_we,
    output logic                 redirect_valid,
    output logic [31:0]          redirect_pc,
    output logic                 int_pending
);

    import csr_addr_pkg::*;

    assign excp_we  = excp_valid;
    assign excp_era = excp_pc;
    assign ertn_we  = ertn && !excp_valid;  // exception takes the slot

    // a fetch fault reports the faulting pc itself
    assign excp_badv_out = (excp_ecode == ECODE_ADEF) ? excp_pc : excp_badv;

    assign int_pending = crmd.f.ie && |(estat.is & ecfg);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= excp_valid || ertn;
        end
    end

    always_ff @(posedge clk) begin
        redirect_pc <= excp_valid ? eentry : era;  // eentry / era before commit
    end

    // entry must leave the old mode in prmd for the handler
    a_prmd_saved: assert property (@(posedge clk) disable iff (!rst_n)
        excp_valid |=> (prmd.pplv == $past(crmd.f.plv)) && (prmd.pie == $past(crmd.f.ie)));

    a_esubcode_adef: assert property (@(posedge clk) disable iff (!rst_n)
        (excp_valid && excp_esubcode != '0) |-> excp_ecode == ECODE_ADEF);

endmodule

//--- hdl/csr_issue.sv
`timescale 1ns/1ps

module csr_issue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    op_valid,
    input  csr_addr_pkg::csr_op_e   op_kind,
    input  csr_addr_pkg::csr_addr_t op_addr,
    input  logic [31:0]             op_wdata,
    input  logic [31:0]             op_mask,
    output csr_addr_pkg::csr_addr_t rd_addr,
    output logic                    wr_en,
    output csr_addr_pkg::csr_addr_t wr_addr,
    output logic [31:0]             wr_data,
    input  logic [31:0]             rd_word,
    output logic                    rd_valid,
    output logic [31:0]             rd_data
);

    import csr_addr_pkg::*;

    logic        q_valid;
    csr_op_e     q_kind;
    csr_addr_t   q_addr;
    logic [31:0] q_wdata;
    logic [31:0] q_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            q_kind  <= op_kind;
            q_addr  <= op_addr;
            q_wdata <= op_wdata;
            q_mask  <= op_mask;
        end
    end

    // old value comes back from the register file in the same cycle
    assign rd_addr  = q_addr;
    assign rd_valid = q_valid;
    assign rd_data  = rd_word;

    assign wr_en   = q_valid && (q_kind != CSR_RD);  // csrrd never writes
    assign wr_addr = q_addr;

    always_comb begin
        case (q_kind)
            CSR_XCHG: wr_data = (rd_word & ~q_mask) | (q_wdata & q_mask);
            default:  wr_data = q_wdata;
        endcase
    end

    a_op_kind_legal: assert property (@(posedge clk) disable iff (!rst_n)
        op_valid |-> op_kind inside {CSR_RD, CSR_WR, CSR_XCHG});

endmodule

//--- hdl/csr_reg_pkg.sv
package csr_reg_pkg;

    typedef struct packed {
        logic [22:0] rsv;   // reads as zero
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_fields_t;

    // csr instructions see the raw word, exception logic sees the fields
    typedef union packed {
        logic [31:0]  raw;
        crmd_fields_t f;
    } crmd_u;

    typedef struct packed {
        logic [28:0] rsv;
        logic        pie;   // ie before the last exception
        logic [1:0]  pplv;  // plv before the last exception
    } prmd_t;

    typedef struct packed {
        logic        rsv31;
        logic [8:0]  esubcode;
        logic [5:0]  ecode;
        logic [2:0]  rsv15_13;
        logic [12:0] is;    // [1:0] swi, [9:2] hwi, [11] timer
    } estat_t;

    typedef struct packed {
        logic [29:0] initval;  // count is initval * 4
        logic        periodic;
        logic        en;
    } tcfg_t;

endpackage

//--- hdl/csr_regfile.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_regfile (
    input  logic                       clk,
    input  logic                       rst_n,
    input  csr_addr_pkg::csr_addr_t    rd_addr,
    input  logic                       wr_en,
    input  csr_addr_pkg::csr_addr_t    wr_addr,
    input  logic [31:0]                wr_data,
    input  logic                       excp_we,
    input  csr_addr_pkg::ecode_t       excp_ecode,
    input  logic [8:0]                 excp_esubcode,
    input  logic [31:0]                excp_era,
    input  logic [31:0]                excp_badv,
    input  logic                       ertn_we,
    input  logic [`CSR_NUM_HWI-1:0]    hwi,
    input  csr_reg_pkg::tcfg_t         tcfg,
    input  logic [`CSR_TIMER_WID-1:0]  tval,
    input  logic                       ti_pulse,
    output logic [31:0]                rd_word,
    output csr_reg_pkg::crmd_u         crmd,
    output csr_reg_pkg::prmd_t         prmd,
    output csr_reg_pkg::estat_t        estat,
    output logic [12:0]                ecfg,
    output logic [31:0]                era,
    output logic [31:0]                eentry
);

    import csr_addr_pkg::*;
    import csr_reg_pkg::*;

    localparam int SAVE_IDX_W = $clog2(`CSR_NUM_SAVE);

    logic                    euen_fpe;
    logic [31:0]             badv;
    logic [25:0]             eentry_hi;  // entry is 64-byte aligned
    logic [31:0]             tid;
    logic [31:0]             save_q [`CSR_NUM_SAVE];
    logic [1:0]              swi_q;
    logic [`CSR_NUM_HWI-1:0] hwi_q;
    logic                    ti_q;
    logic [5:0]              ecode_q;
    logic [8:0]              esubcode_q;
    logic                    inst_we;
    csr_addr_t               rd_save_off;
    csr_addr_t               wr_save_off;
    logic                    rd_save_hit;
    logic                    wr_save_hit;

    // an exception in the same cycle wins over the csr instruction
    assign inst_we = wr_en && !excp_we;

    assign rd_save_off = rd_addr - CSR_SAVE0;
    assign wr_save_off = wr_addr - CSR_SAVE0;
    assign rd_save_hit = rd_save_off < csr_addr_t'(`CSR_NUM_SAVE);
    assign wr_save_hit = wr_save_off < csr_addr_t'(`CSR_NUM_SAVE);

    assign eentry = {eentry_hi, 6'b0};

    always_comb begin
        estat                       = '0;
        estat.is[1:0]               = swi_q;
        estat.is[2 +: `CSR_NUM_HWI] = hwi_q;
        estat.is[11]                = ti_q;
        estat.ecode                 = ecode_q;
        estat.esubcode              = esubcode_q;
    end

    always_comb begin
        rd_word = '0;
        case (rd_addr)
            CSR_CRMD:   rd_word = crmd.raw;
            CSR_PRMD:   rd_word = prmd;
            CSR_EUEN:   rd_word = {31'b0, euen_fpe};
            CSR_ECFG:   rd_word = {19'b0, ecfg};
            CSR_ESTAT:  rd_word = estat;
            CSR_ERA:    rd_word = era;
            CSR_BADV:   rd_word = badv;
            CSR_EENTRY: rd_word = eentry;
            CSR_TID:    rd_word = tid;
            CSR_TCFG:   rd_word = tcfg;
            CSR_TVAL:   rd_word = 32'(tval);
            CSR_TICLR:  rd_word = '0;  // write-one-to-clear only
            default: begin
                if (rd_save_hit) begin
                    rd_word = save_q[rd_save_off[SAVE_IDX_W-1:0]];
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd.raw   <= 32'h0000_0008;  // da=1
            prmd       <= '0;
            euen_fpe   <= 1'b0;
            ecfg       <= '0;
            ecode_q    <= '0;
            esubcode_q <= '0;
            for (int i = 0; i < `CSR_NUM_SAVE; i++) begin
                save_q[i] <= '0;
            end
        end else if (excp_we) begin
            prmd.pplv  <= crmd.f.plv;
            prmd.pie   <= crmd.f.ie;
            crmd.f.plv <= 2'd0;
            crmd.f.ie  <= 1'b0;
            ecode_q    <= excp_ecode;
            esubcode_q <= excp_esubcode;
        end else if (inst_we) begin
            case (wr_addr)
                CSR_CRMD: crmd.raw <= wr_data & 32'h0000_01ff;
                CSR_PRMD: prmd     <= prmd_t'({29'b0, wr_data[2:0]});
                CSR_EUEN: euen_fpe <= wr_data[0];
                CSR_ECFG: ecfg     <= wr_data[12:0];
                default: begin
                    if (wr_save_hit) begin
                        save_q[wr_save_off[SAVE_IDX_W-1:0]] <= wr_data;
                    end
                end
            endcase
        end else if (ertn_we) begin
            crmd.f.plv <= prmd.pplv;  // back to the interrupted mode
            crmd.f.ie  <= prmd.pie;
        end
    end

    always_ff @(posedge clk) begin
        if (excp_we) begin
            era  <= excp_era;
            badv <= excp_badv;
        end else if (inst_we) begin
            case (wr_addr)
                CSR_ERA:    era       <= wr_data;
                CSR_BADV:   badv      <= wr_data;
                CSR_EENTRY: eentry_hi <= wr_data[31:6];
                CSR_TID:    tid       <= wr_data;
                default:    ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            swi_q <= '0;
            hwi_q <= '0;
            ti_q  <= 1'b0;
        end else begin
            hwi_q <= hwi;  // level, resampled each cycle
            if (inst_we && wr_addr == CSR_ESTAT) begin
                swi_q <= wr_data[1:0];
            end
            if (ti_pulse) begin
                ti_q <= 1'b1;  // sticky until ticlr
            end else if (inst_we && wr_addr == CSR_TICLR && wr_data[0]) begin
                ti_q <= 1'b0;
            end
        end
    end

    a_excp_ertn_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(excp_we && ertn_we));

endmodule

//--- hdl/csr_timer.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_timer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_en,
    input  csr_addr_pkg::csr_addr_t    wr_addr,
    input  logic [31:0]                wr_data,
    output csr_reg_pkg::tcfg_t         tcfg,
    output logic [`CSR_TIMER_WID-1:0]  tval,
    output logic                       ti_pulse
);

    import csr_addr_pkg::*;
    import csr_reg_pkg::*;

    tcfg_t tcfg_w;
    logic  tcfg_we;
    logic  run;  // counting, cleared when a one-shot expires

    assign tcfg_we  = wr_en && (wr_addr == CSR_TCFG);
    assign tcfg_w   = tcfg_t'(wr_data);
    assign ti_pulse = run && (tval == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tcfg <= '0;
            tval <= '0;
            run  <= 1'b0;
        end else if (tcfg_we) begin
            tcfg <= tcfg_w;
            tval <= `CSR_TIMER_WID'({tcfg_w.initval, 2'b00});
            run  <= tcfg_w.en;
        end else if (ti_pulse) begin
            if (tcfg.periodic) begin
                tval <= `CSR_TIMER_WID'({tcfg.initval, 2'b00});
            end else begin
                run <= 1'b0;  // one-shot, hold at zero
            end
        end else if (run) begin
            tval <= tval - 1'b1;
        end
    end

    a_tval_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (!tcfg.en && !tcfg_we) |=> $stable(tval));

endmodule

//--- hdl/csr_top.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    op_valid,
    input  csr_addr_pkg::csr_op_e   op_kind,
    input  csr_addr_pkg::csr_addr_t op_addr,
    input  logic [31:0]             op_wdata,
    input  logic [31:0]             op_mask,
    input  logic [`CSR_NUM_HWI-1:0] hwi,
    input  logic                    excp_valid,
    input  csr_addr_pkg::ecode_t    excp_ecode,
    input  logic [8:0]              excp_esubcode,
    input  logic [31:0]             excp_pc,
    input  logic [31:0]             excp_badv,
    input  logic                    ertn,
    output logic                    rd_valid,
    output logic [31:0]             rd_data,
    output logic                    redirect_valid,
    output logic [31:0]             redirect_pc,
    output logic                    int_pending
);

    csr_addr_pkg::csr_addr_t   rd_addr;
    logic [31:0]               rd_word;
    logic                      wr_en;
    csr_addr_pkg::csr_addr_t   wr_addr;
    logic [31:0]               wr_data;
    logic                      excp_we;
    logic [31:0]               excp_era;
    logic [31:0]               excp_badv_w;
    logic                      ertn_we;
    csr_reg_pkg::crmd_u        crmd;
    csr_reg_pkg::prmd_t        prmd;
    csr_reg_pkg::estat_t       estat;
    logic [12:0]               ecfg;
    logic [31:0]               era;
    logic [31:0]               eentry;
    csr_reg_pkg::tcfg_t        tcfg;
    logic [`CSR_TIMER_WID-1:0] tval;
    logic                      ti_pulse;

    csr_issue issue_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_valid (op_valid),
        .op_kind  (op_kind),
        .op_addr  (op_addr),
        .op_wdata (op_wdata),
        .op_mask  (op_mask),
        .rd_addr  (rd_addr),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_word  (rd_word),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    csr_regfile regfile_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_addr       (rd_addr),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .excp_we       (excp_we),
        .excp_ecode    (excp_ecode),
        .excp_esubcode (excp_esubcode),
        .excp_era      (excp_era),
        .excp_badv     (excp_badv_w),
        .ertn_we       (ertn_we),
        .hwi           (hwi),
        .tcfg          (tcfg),
        .tval          (tval),
        .ti_pulse      (ti_pulse),
        .rd_word       (rd_word),
        .crmd          (crmd),
        .prmd          (prmd),
        .estat         (estat),
        .ecfg          (ecfg),
        .era           (era),
        .eentry        (eentry)
    );

    csr_timer timer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .tcfg     (tcfg),
        .tval     (tval),
        .ti_pulse (ti_pulse)
    );

    csr_excp excp_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .excp_valid     (excp_valid),
        .excp_ecode     (excp_ecode),
        .excp_esubcode  (excp_esubcode),
        .excp_pc        (excp_pc),
        .excp_badv      (excp_badv),
        .ertn           (ertn),
        .crmd           (crmd),
        .prmd           (prmd),
        .estat          (estat),
        .ecfg           (ecfg),
        .era            (era),
        .eentry         (eentry),
        .excp_we        (excp_we),
        .excp_era       (excp_era),
        .excp_badv_out  (excp_badv_w),
        .ertn_we        (ertn_we),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .int_pending    (int_pending)
    );

endmodule

//--- tb.f
+incdir+hdl
hdl/csr_addr_pkg.sv
hdl/csr_reg_pkg.sv
hdl/csr_issue.sv
hdl/csr_regfile.sv
hdl/csr_timer.sv
hdl/csr_excp.sv
hdl/csr_top.sv
verif/csr_tb.sv

//--- verif/csr_tb.sv
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_tb;

    import csr_addr_pkg::*;

    localparam int CLK_NS   = 4;
    localparam int N_OPS    = 200;
    localparam int WDOG_CYC = 4 * N_OPS + 600;  // random phase plus directed tests

    logic                    clk;
    logic                    rst_n;
    logic                    op_valid;
    csr_op_e                 op_kind;
    csr_addr_t               op_addr;
    logic [31:0]             op_wdata;
    logic [31:0]             op_mask;
    logic [`CSR_NUM_HWI-1:0] hwi;
    logic                    excp_valid;
    ecode_t                  excp_ecode;
    logic [8:0]              excp_esubcode;
    logic [31:0]             excp_pc;
    logic [31:0]             excp_badv;
    logic                    ertn;
    logic                    rd_valid;
    logic [31:0]             rd_data;
    logic                    redirect_valid;
    logic [31:0]             redirect_pc;
    logic                    int_pending;

    logic [31:0]             m_crmd;  // reference copy of the CSR state
    logic [31:0]             m_prmd;
    logic [31:0]             m_ecfg;
    logic [31:0]             m_era;
    logic [31:0]             m_eentry;
    logic [31:0]             m_save [`CSR_NUM_SAVE];
    logic [1:0]              m_swi;
    logic [`CSR_NUM_HWI-1:0] m_hwi;
    logic                    m_ti;
    logic [5:0]              m_ecode;

    string       rd_name_q   [$];  // expected responses, oldest first
    logic [31:0] rd_exp_q    [$];
    logic [31:0] rd_care_q   [$];
    string       rdir_name_q [$];
    logic [31:0] rdir_exp_q  [$];

    int          data_errs = 0;
    int          rdir_errs = 0;
    int          misc_errs = 0;
    logic [31:0] lcg_state = 32'd28724;

    csr_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .op_valid       (op_valid),
        .op_kind        (op_kind),
        .op_addr        (op_addr),
        .op_wdata       (op_wdata),
        .op_mask        (op_mask),
        .hwi            (hwi),
        .excp_valid     (excp_valid),
        .excp_ecode     (excp_ecode),
        .excp_esubcode  (excp_esubcode),
        .excp_pc        (excp_pc),
        .excp_badv      (excp_badv),
        .ertn           (ertn),
        .rd_valid       (rd_valid),
        .rd_data        (rd_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .int_pending    (int_pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic csr_addr_t pick_addr(logic [2:0] idx);
        case (idx)
            3'd0:    return CSR_SAVE0;
            3'd1:    return CSR_SAVE1;
            3'd2:    return CSR_SAVE2;
            3'd3:    return CSR_SAVE3;
            3'd4:    return CSR_ERA;
            3'd5:    return CSR_EENTRY;
            default: return CSR_ECFG;
        endcase
    endfunction

    function automatic logic [31:0] writable_bits(csr_addr_t addr);
        case (addr)
            CSR_CRMD:   return 32'h0000_01ff;
            CSR_PRMD:   return 32'h0000_0007;
            CSR_ECFG:   return 32'h0000_1fff;
            CSR_ESTAT:  return 32'h0000_0003;  // software bits only
            CSR_EENTRY: return 32'hffff_ffc0;
            default:    return 32'hffff_ffff;
        endcase
    endfunction

    function automatic logic [31:0] model_read(csr_addr_t addr);
        case (addr)
            CSR_CRMD:   return m_crmd;
            CSR_PRMD:   return m_prmd;
            CSR_ECFG:   return m_ecfg;
            CSR_ESTAT:  return {10'b0, m_ecode, 3'b0, 1'b0, m_ti, 1'b0, m_hwi, m_swi};
            CSR_ERA:    return m_era;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return m_save[addr[1:0]];
            default:    return 32'h0;
        endcase
    endfunction

    // per bit, mask 1 takes the new data and mask 0 keeps the old value
    function automatic logic [31:0] merge_write(csr_op_e kind, logic [31:0] old,
                                                logic [31:0] wdata, logic [31:0] mask);
        logic [31:0] res;
        res = wdata;
        if (kind == CSR_XCHG) begin
            for (int i = 0; i < 32; i++) begin
                res[i] = mask[i] ? wdata[i] : old[i];
            end
        end
        return res;
    endfunction

    function automatic void model_write(csr_addr_t addr, logic [31:0] data);
        logic [31:0] v;
        v = data & writable_bits(addr);
        case (addr)
            CSR_CRMD:   m_crmd = v;
            CSR_PRMD:   m_prmd = v;
            CSR_ECFG:   m_ecfg = v;
            CSR_ESTAT:  m_swi = v[1:0];
            CSR_ERA:    m_era = v;
            CSR_EENTRY: m_eentry = v;
            CSR_TICLR:  if (data[0]) m_ti = 1'b0;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: m_save[addr[1:0]] = v;
            default:    ;
        endcase
    endfunction

    function automatic logic int_expect();
        logic [31:0] st;
        st = model_read(CSR_ESTAT);
        return m_crmd[2] && ((st[12:0] & m_ecfg[12:0]) != 13'b0);
    endfunction

    task automatic drop_strobes();
        op_valid   <= 1'b0;
        excp_valid <= 1'b0;
        ertn       <= 1'b0;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            drop_strobes();
        end
    endtask

    task automatic csr_op(csr_op_e kind, csr_addr_t addr, logic [31:0] wdata,
                          logic [31:0] mask, logic [31:0] care, string name);
        logic [31:0] old;
        old = model_read(addr);
        @(posedge clk);
        drop_strobes();
        op_valid <= 1'b1;
        op_kind  <= kind;
        op_addr  <= addr;
        op_wdata <= wdata;
        op_mask  <= mask;
        rd_name_q.push_back(name);
        rd_exp_q.push_back(old);
        rd_care_q.push_back(care);
        if (kind != CSR_RD) begin
            model_write(addr, merge_write(kind, old, wdata, mask));
        end
    endtask

    task automatic read_now(csr_addr_t addr, logic [31:0] care, string name,
                            output logic [31:0] data);
        csr_op(CSR_RD, addr, '0, '0, care, name);
        idle(1);
        @(negedge clk);
        while (!rd_valid) @(negedge clk);
        data = rd_data;
    endtask

    task automatic take_exception(ecode_t code, logic [31:0] pc);
        idle(1);  // let earlier csr writes commit first
        @(posedge clk);
        drop_strobes();
        excp_valid    <= 1'b1;
        excp_ecode    <= code;
        excp_esubcode <= '0;
        excp_pc       <= pc;
        excp_badv     <= lcg_next();
        rdir_name_q.push_back("exception redirect");
        rdir_exp_q.push_back(m_eentry);
        m_prmd      = {29'b0, m_crmd[2], m_crmd[1:0]};
        m_crmd[2:0] = 3'b000;
        m_ecode     = code;
        m_era       = pc;
    endtask

    task automatic do_ertn();
        idle(1);
        @(posedge clk);
        drop_strobes();
        ertn <= 1'b1;
        rdir_name_q.push_back("ertn redirect");
        rdir_exp_q.push_back(m_era);
        m_crmd[2:0] = m_prmd[2:0];
    endtask

    task automatic set_hwi(logic [`CSR_NUM_HWI-1:0] v);
        @(posedge clk);
        drop_strobes();
        hwi   <= v;
        m_hwi = v;
    endtask

    task automatic check_int(string name);
        idle(2);  // last write commits one edge after issue
        @(negedge clk);
        assert (int_pending === int_expect()) else begin
            data_errs++;
            $display("** Error %s: expected %0b, actual %0b", name, int_expect(), int_pending);
        end
    endtask

    always @(negedge clk) begin : compare
        string       name;
        logic [31:0] exp;
        logic [31:0] care;
        if (rd_valid) begin
            assert (rd_exp_q.size() > 0) else begin
                misc_errs++;
                $display("read response at %0t with no request outstanding", $time);
            end
            if (rd_exp_q.size() > 0) begin
                name = rd_name_q.pop_front();
                exp  = rd_exp_q.pop_front() & rd_care_q[0];
                care = rd_care_q.pop_front();
                assert ((rd_data & care) === exp) else begin
                    data_errs++;
                    $display("** Error %s: expected %h, actual %h", name, exp, rd_data & care);
                end
            end
        end
        if (redirect_valid) begin
            assert (rdir_exp_q.size() > 0) else begin
                misc_errs++;
                $display("redirect at %0t with no exception or ertn outstanding", $time);
            end
            if (rdir_exp_q.size() > 0) begin
                name = rdir_name_q.pop_front();
                exp  = rdir_exp_q.pop_front();
                assert (redirect_pc === exp) else begin
                    rdir_errs++;
                    $display("** Error %s: expected %h, actual %h", name, exp, redirect_pc);
                end
            end
        end
    end

    initial begin
        #(WDOG_CYC * CLK_NS);
        $display("watchdog expired after %0d cycles, the run did not finish", WDOG_CYC);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] v;
        csr_op_e     kind;
        logic        seen;
        int          bound;
        rst_n         = 1'b0;
        op_valid      = 1'b0;
        op_kind       = CSR_RD;
        op_addr       = '0;
        op_wdata      = '0;
        op_mask       = '0;
        hwi           = '0;
        excp_valid    = 1'b0;
        excp_ecode    = ECODE_INT;
        excp_esubcode = '0;
        excp_pc       = '0;
        excp_badv     = '0;
        ertn          = 1'b0;
        m_crmd        = 32'h0000_0008;  // da set out of reset
        m_prmd        = '0;
        m_ecfg        = '0;
        m_era         = '0;
        m_eentry      = '0;
        m_swi         = '0;
        m_hwi         = '0;
        m_ti          = 1'b0;
        m_ecode       = '0;
        for (int i = 0; i < `CSR_NUM_SAVE; i++) begin
            m_save[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        csr_op(CSR_RD, CSR_CRMD, '0, '0, '1, "reset crmd");
        csr_op(CSR_RD, CSR_PRMD, '0, '0, '1, "reset prmd");
        csr_op(CSR_RD, CSR_ECFG, '0, '0, '1, "reset ecfg");
        csr_op(CSR_RD, CSR_ESTAT, '0, '0, '1, "reset estat");
        for (int i = 0; i < `CSR_NUM_SAVE; i++) begin
            csr_op(CSR_RD, csr_addr_t'(CSR_SAVE0 + i), '0, '0, '1,
                   $sformatf("reset save%0d", i));
        end

        // era and eentry have no reset value, so their old value is not checked here
        csr_op(CSR_WR, CSR_ERA, lcg_next(), '0, '0, "init era");
        csr_op(CSR_WR, CSR_EENTRY, lcg_next(), '0, '0, "init eentry");
        for (int n = 0; n < N_OPS; n++) begin
            r    = lcg_next();
            kind = csr_op_e'(r[29:28] % 2'd3);
            csr_op(kind, pick_addr(r[26:24] % 3'd7), lcg_next(), lcg_next(), '1,
                   $sformatf("random op %0d", n));
            if (r[21:20] == 2'd0) begin
                idle(1 + r[19:18]);  // mostly back to back
            end
        end

        csr_op(CSR_WR, CSR_CRMD, 32'h0000_000f, '0, '1, "crmd plv3 ie");
        take_exception(ECODE_SYS, lcg_next());
        csr_op(CSR_RD, CSR_CRMD, '0, '0, '1, "crmd after entry");
        csr_op(CSR_RD, CSR_PRMD, '0, '0, '1, "prmd after entry");
        csr_op(CSR_RD, CSR_ESTAT, '0, '0, '1, "estat ecode");
        csr_op(CSR_RD, CSR_ERA, '0, '0, '1, "era after entry");

        do_ertn();
        csr_op(CSR_RD, CSR_CRMD, '0, '0, '1, "crmd after ertn");

        csr_op(CSR_WR, CSR_ECFG, 32'h0000_0800, '0, '1, "ecfg timer lie");
        csr_op(CSR_WR, CSR_TCFG, 32'h0000_000d, '0, '1, "tcfg one-shot");  // initval 3, en
        idle(1);
        bound = 3 * 4 + 2;
        seen  = 1'b0;
        for (int n = 1; n <= bound + 1 && !seen; n += 2) begin
            read_now(CSR_ESTAT, ~32'h0000_0800, "estat timer poll", v);
            seen = v[11];
        end
        assert (seen) else begin
            misc_errs++;
            $display("timer interrupt bit not set within %0d cycles", bound);
        end
        m_ti = 1'b1;
        check_int("int_pending timer");
        csr_op(CSR_WR, CSR_TICLR, 32'h0000_0001, '0, '1, "ticlr write");
        csr_op(CSR_RD, CSR_ESTAT, '0, '0, '1, "estat after ticlr");
        check_int("int_pending after ticlr");

        csr_op(CSR_WR, CSR_ECFG, 32'h0000_0001, '0, '1, "ecfg swi0 lie");
        csr_op(CSR_WR, CSR_ESTAT, 32'h0000_0001, '0, '1, "estat swi0");
        check_int("int_pending swi0");
        csr_op(CSR_WR, CSR_ECFG, 32'h0000_0000, '0, '1, "ecfg clear");
        check_int("int_pending no lie");
        set_hwi(8'h24);
        csr_op(CSR_WR, CSR_ECFG, 32'h0000_03fc, '0, '1, "ecfg hwi lie");
        csr_op(CSR_RD, CSR_ESTAT, '0, '0, '1, "estat hwi");
        check_int("int_pending hwi");
        csr_op(CSR_XCHG, CSR_ESTAT, 32'h0000_0002, 32'h0000_0003, '1, "estat swi xchg");
        csr_op(CSR_WR, CSR_CRMD, 32'h0000_0008, '0, '1, "crmd ie off");
        check_int("int_pending ie off");
        set_hwi('0);
        csr_op(CSR_WR, CSR_CRMD, 32'h0000_0004, '0, '1, "crmd ie on");
        csr_op(CSR_RD, CSR_ESTAT, '0, '0, '1, "estat swi1 only");
        check_int("int_pending hwi low");

        idle(4);
        assert (rd_exp_q.size() == 0 && rdir_exp_q.size() == 0) else begin
            misc_errs++;
            $display("%0d reads and %0d redirects never arrived",
                     rd_exp_q.size(), rdir_exp_q.size());
        end
        $display("errors: read data %0d, redirect %0d, other %0d",
                 data_errs, rdir_errs, misc_errs);
        if (data_errs + rdir_errs + misc_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
